// File: src/cpu_consts.svh
// CPU constants
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define CPU_DATA_W   32
`define CPU_PC_W     8
`define CPU_REG_AW   5
`define CPU_DMEM_AW  6     // word address, taken from bits 7..2
`define CPU_LED_W    27

`define CPU_OP_RTYPE 6'h00
`define CPU_OP_MUL   6'h1c
`define CPU_OP_ADDI  6'h08
`define CPU_OP_LW    6'h23
`define CPU_OP_SW    6'h2b

`define CPU_FN_ADD   6'h20
`define CPU_FN_SUB   6'h22
`define CPU_FN_AND   6'h24
`define CPU_FN_OR    6'h25
`define CPU_FN_SLT   6'h2a
`define CPU_FN_SLL   6'h00
`define CPU_FN_MUL   6'h02 // only together with opcode 0x1c

`define CPU_LED_FETCH 3'd0
`define CPU_LED_RS    3'd1
`define CPU_LED_ALU   3'd2
`define CPU_LED_FLAGS 3'd3
`define CPU_LED_MEMRD 3'd4
`define CPU_LED_CTRL  3'd5
`define CPU_LED_ALUOP 3'd6
`define CPU_LED_PC    3'd7

`endif

// File: src/cpu_pkg.sv
// CPU shared types
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`CPU_REG_AW-1:0] rs;
        logic [`CPU_REG_AW-1:0] rt;
        logic [`CPU_REG_AW-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`CPU_REG_AW-1:0] rs;
        logic [`CPU_REG_AW-1:0] rt;
        logic [15:0]            imm;
    } i_fmt_t;

    // one instruction word, seen as R or I format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4,
        ALU_SLL = 4'd5,
        ALU_MUL = 4'd6
    } alu_op_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src_imm;
        alu_op_t alu_op;
    } ctrl_t;                   // all zero is a bubble

endpackage

`default_nettype wire

// File: src/cpu_ifs.sv
// Pipeline stage interfaces
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

interface id_ex_if import cpu_pkg::*; ();

    ctrl_t                   ctrl;
    logic [`CPU_DATA_W-1:0]  rs_val;     // after forwarding
    logic [`CPU_DATA_W-1:0]  rt_val;
    logic [`CPU_DATA_W-1:0]  imm;        // sign extended
    logic [4:0]              shamt;
    logic [`CPU_REG_AW-1:0]  dest;
    logic [`CPU_REG_AW-1:0]  rs_addr;
    logic [`CPU_REG_AW-1:0]  rt_addr;

    modport src (output ctrl, rs_val, rt_val, imm, shamt, dest, rs_addr, rt_addr);
    modport dst (input ctrl, rs_val, rt_val, imm, shamt, dest);
    modport mon (input rs_addr, rt_addr); // source regs of the decode instruction

endinterface

interface ex_mem_if import cpu_pkg::*; ();

    ctrl_t                   ctrl;
    logic [`CPU_DATA_W-1:0]  alu_result;
    logic [`CPU_DATA_W-1:0]  store_data;
    logic [`CPU_REG_AW-1:0]  dest;

    modport src (output ctrl, alu_result, store_data, dest);
    modport dst (input ctrl, alu_result, store_data, dest);
    modport mon (input ctrl, dest);      // instruction now in execute

endinterface

`default_nettype wire

// File: src/fetch_stage.sv
// Fetch stage
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  logic                   load,
    input  logic [`CPU_PC_W-1:0]   pc_val,
    input  logic                   stall,
    input  logic                   imem_we,
    input  logic [`CPU_PC_W-1:0]   imem_addr,
    input  logic [`CPU_DATA_W-1:0] imem_data,
    output logic [`CPU_PC_W-1:0]   pc,
    output instr_t                 instr
);

    logic [`CPU_DATA_W-1:0] imem [2**`CPU_PC_W];   // program store, loaded from outside

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc <= '0;
        end
        else if (load)
        begin
            pc <= pc_val;          // user load beats stall
        end
        else if (!stall)
        begin
            pc <= pc + 1'b1;       // word addressed
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (imem_we)
        begin
            imem[imem_addr] <= imem_data;
        end
    end

    assign instr = imem[pc];       // async read

endmodule

`default_nettype wire

// File: src/decode_stage.sv
// Decode stage and register file
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module decode_stage import cpu_pkg::*; (
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  logic                   load,
    input  logic                   stall,
    input  instr_t                 f_instr,
    input  logic                   wb_en,
    input  logic [`CPU_REG_AW-1:0] wb_addr,
    input  logic [`CPU_DATA_W-1:0] wb_data,
    input  logic                   fwd_rs,
    input  logic                   fwd_rt,
    input  logic [`CPU_DATA_W-1:0] mem_alu_result,
    input  logic [`CPU_REG_AW-1:0] reg_sel,
    output instr_t                 d_instr,
    output logic [`CPU_DATA_W-1:0] rs_view,
    output logic [`CPU_DATA_W-1:0] reg_value,
    id_ex_if.src                   id_ex
);

    logic [`CPU_DATA_W-1:0] regs [2**`CPU_REG_AW];
    logic [`CPU_DATA_W-1:0] rs_raw;
    logic [`CPU_DATA_W-1:0] rt_raw;
    logic                   wb_live;
    logic                   is_rtype;
    ctrl_t                  ctrl_dec;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            d_instr <= '0;
        else if (load)
            d_instr <= '0;          // bubble behind a pc load
        else if (!stall)
            d_instr <= f_instr;
    end

    // main control, alu op chosen here from opcode and funct
    always_comb
    begin
        ctrl_dec = '0;
        case (d_instr.r_fmt.opcode)
            `CPU_OP_RTYPE:
            begin
                ctrl_dec.reg_write = 1'b1;
                case (d_instr.r_fmt.funct)
                    `CPU_FN_ADD: ctrl_dec.alu_op = ALU_ADD;
                    `CPU_FN_SUB: ctrl_dec.alu_op = ALU_SUB;
                    `CPU_FN_AND: ctrl_dec.alu_op = ALU_AND;
                    `CPU_FN_OR:  ctrl_dec.alu_op = ALU_OR;
                    `CPU_FN_SLT: ctrl_dec.alu_op = ALU_SLT;
                    `CPU_FN_SLL: ctrl_dec.alu_op = ALU_SLL;
                    default:     ctrl_dec = '0;
                endcase
            end
            `CPU_OP_MUL:
            begin
                if (d_instr.r_fmt.funct == `CPU_FN_MUL)
                begin
                    ctrl_dec.reg_write = 1'b1;
                    ctrl_dec.alu_op    = ALU_MUL;
                end
            end
            `CPU_OP_ADDI: ctrl_dec = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, ALU_ADD};
            `CPU_OP_LW:   ctrl_dec = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1, ALU_ADD};
            `CPU_OP_SW:   ctrl_dec = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, ALU_ADD};
            default:      ctrl_dec = '0;   // unknown opcode
        endcase
    end

    assign is_rtype = (d_instr.r_fmt.opcode == `CPU_OP_RTYPE) ||
                      (d_instr.r_fmt.opcode == `CPU_OP_MUL);

    // register file, r0 never written so it stays zero
    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 2**`CPU_REG_AW; i++)
                regs[i] <= '0;
        end
        else if (wb_live)
        begin
            regs[wb_addr] <= wb_data;
        end
    end

    assign wb_live   = wb_en && (wb_addr != '0);
    assign rs_raw    = (wb_live && wb_addr == d_instr.r_fmt.rs) ? wb_data : regs[d_instr.r_fmt.rs];
    assign rt_raw    = (wb_live && wb_addr == d_instr.r_fmt.rt) ? wb_data : regs[d_instr.r_fmt.rt];
    assign reg_value = (wb_live && wb_addr == reg_sel) ? wb_data : regs[reg_sel];

    assign rs_view       = fwd_rs ? mem_alu_result : rs_raw;   // forward from memory
    assign id_ex.rs_val  = rs_view;
    assign id_ex.rt_val  = fwd_rt ? mem_alu_result : rt_raw;
    assign id_ex.ctrl    = stall ? ctrl_t'('0) : ctrl_dec;     // bubble while stalled
    assign id_ex.imm     = {{(`CPU_DATA_W-16){d_instr.i_fmt.imm[15]}}, d_instr.i_fmt.imm};
    assign id_ex.shamt   = d_instr.r_fmt.shamt;
    assign id_ex.dest    = is_rtype ? d_instr.r_fmt.rd : d_instr.r_fmt.rt;
    assign id_ex.rs_addr = d_instr.r_fmt.rs;
    assign id_ex.rt_addr = d_instr.r_fmt.rt;

    a_no_fwd_on_nop: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        (d_instr == '0) |-> !(fwd_rs || fwd_rt))
        else $error("forward select set on a nop");

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
// Stall and forward detection
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module hazard_unit import cpu_pkg::*; (
    input  instr_t                 d_instr,
    id_ex_if.mon                   id_ex,
    ex_mem_if.mon                  ex_mem,
    input  ctrl_t                  mem_ctrl,   // instruction in the memory stage
    input  logic [`CPU_REG_AW-1:0] mem_dest,
    output logic                   stall,
    output logic                   fwd_rs,
    output logic                   fwd_rt
);

    logic reads_rs;
    logic reads_rt;
    logic ex_hit;
    logic load_hit;
    logic mem_alu;

    function automatic logic hit(input logic [`CPU_REG_AW-1:0] dest,
                                 input logic [`CPU_REG_AW-1:0] src,
                                 input logic                   used);
        return used && (dest != '0) && (dest == src);
    endfunction

    // which source regs the decode instruction really reads
    always_comb
    begin
        reads_rs = 1'b0;
        reads_rt = 1'b0;
        case (d_instr.r_fmt.opcode)
            `CPU_OP_RTYPE, `CPU_OP_MUL, `CPU_OP_SW:
            begin
                reads_rs = 1'b1;
                reads_rt = 1'b1;
            end
            `CPU_OP_ADDI, `CPU_OP_LW: reads_rs = 1'b1;
            default: ;
        endcase
    end

    assign ex_hit   = ex_mem.ctrl.reg_write &&
                      (hit(ex_mem.dest, id_ex.rs_addr, reads_rs) ||
                       hit(ex_mem.dest, id_ex.rt_addr, reads_rt));
    assign load_hit = mem_ctrl.mem_read &&
                      (hit(mem_dest, id_ex.rs_addr, reads_rs) ||
                       hit(mem_dest, id_ex.rt_addr, reads_rt));   // load data not ready yet
    assign stall    = ex_hit || load_hit;

    assign mem_alu  = mem_ctrl.reg_write && !mem_ctrl.mem_read;
    assign fwd_rs   = mem_alu && hit(mem_dest, id_ex.rs_addr, reads_rs);
    assign fwd_rt   = mem_alu && hit(mem_dest, id_ex.rt_addr, reads_rt);

endmodule

`default_nettype wire

// File: src/execute_stage.sv
// Execute stage and ALU
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module execute_stage import cpu_pkg::*; (
    input  logic       SYS_clk,
    input  logic       SYS_reset,
    id_ex_if.dst       id_ex,
    ex_mem_if.src      ex_mem,
    output logic [1:0] alu_flags       // {zero, sign}
);

    ctrl_t                  x_ctrl;
    logic [`CPU_DATA_W-1:0] x_rs;
    logic [`CPU_DATA_W-1:0] x_rt;
    logic [`CPU_DATA_W-1:0] x_imm;
    logic [4:0]             x_shamt;
    logic [`CPU_REG_AW-1:0] x_dest;
    logic [`CPU_DATA_W-1:0] op_b;
    logic [`CPU_DATA_W-1:0] alu_result;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            x_ctrl <= '0;
        else
            x_ctrl <= id_ex.ctrl;
    end

    always_ff @(posedge SYS_clk)
    begin
        x_rs    <= id_ex.rs_val;
        x_rt    <= id_ex.rt_val;
        x_imm   <= id_ex.imm;
        x_shamt <= id_ex.shamt;
        x_dest  <= id_ex.dest;
    end

    assign op_b = x_ctrl.alu_src_imm ? x_imm : x_rt;

    always_comb
    begin
        case (x_ctrl.alu_op)
            ALU_ADD: alu_result = x_rs + op_b;                  // wraps
            ALU_SUB: alu_result = x_rs - op_b;
            ALU_AND: alu_result = x_rs & op_b;
            ALU_OR:  alu_result = x_rs | op_b;
            ALU_SLT: alu_result = {{(`CPU_DATA_W-1){1'b0}}, $signed(x_rs) < $signed(op_b)};
            ALU_SLL: alu_result = op_b << x_shamt;              // shifts rt
            ALU_MUL: alu_result = x_rs * op_b;                  // low word only
            default: alu_result = '0;
        endcase
    end

    assign alu_flags         = {alu_result == '0, alu_result[`CPU_DATA_W-1]};
    assign ex_mem.ctrl       = x_ctrl;
    assign ex_mem.alu_result = alu_result;
    assign ex_mem.store_data = x_rt;
    assign ex_mem.dest       = x_dest;

    a_alu_op_known: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        x_ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_MUL})
        else $error("unknown alu op %h", x_ctrl.alu_op);

endmodule

`default_nettype wire

// File: src/memory_stage.sv
// Memory and writeback stages
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module memory_stage import cpu_pkg::*; (
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    ex_mem_if.dst                  ex_mem,
    output ctrl_t                  mem_ctrl,
    output logic [`CPU_REG_AW-1:0] mem_dest,
    output logic [`CPU_DATA_W-1:0] mem_alu_result,
    output logic [`CPU_DATA_W-1:0] read_data,
    output logic                   wb_en,
    output logic [`CPU_REG_AW-1:0] wb_addr,
    output logic [`CPU_DATA_W-1:0] wb_data
);

    logic [`CPU_DATA_W-1:0] dmem [2**`CPU_DMEM_AW];
    logic [`CPU_DATA_W-1:0] m_store;
    logic [`CPU_DMEM_AW-1:0] m_word;
    logic                   wb_mem_to_reg;
    logic [`CPU_DATA_W-1:0] wb_load;
    logic [`CPU_DATA_W-1:0] wb_alu;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            mem_ctrl      <= '0;
            wb_en         <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end
        else
        begin
            mem_ctrl      <= ex_mem.ctrl;
            wb_en         <= mem_ctrl.reg_write;
            wb_mem_to_reg <= mem_ctrl.mem_to_reg;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        mem_alu_result <= ex_mem.alu_result;
        m_store        <= ex_mem.store_data;
        mem_dest       <= ex_mem.dest;
        wb_addr        <= mem_dest;
        wb_load        <= read_data;
        wb_alu         <= mem_alu_result;
        if (mem_ctrl.mem_write)
            dmem[m_word] <= m_store;
    end

    assign m_word    = mem_alu_result[`CPU_DMEM_AW+1:2];   // byte offset ignored
    assign read_data = dmem[m_word];
    assign wb_data   = wb_mem_to_reg ? wb_load : wb_alu;

    a_rd_wr_excl: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !(mem_ctrl.mem_read && mem_ctrl.mem_write))
        else $error("load and store in the same slot");

endmodule

`default_nettype wire

// File: src/mips_core.sv
// Pipelined MIPS core
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module mips_core import cpu_pkg::*; (
    input  logic                   SYS_clk,
    input  logic                   SYS_reset,
    input  logic                   load,
    input  logic [`CPU_PC_W-1:0]   pc_val,
    input  logic [2:0]             output_sel,
    output logic [`CPU_LED_W-1:0]  leds,
    input  logic                   imem_we,
    input  logic [`CPU_PC_W-1:0]   imem_addr,
    input  logic [`CPU_DATA_W-1:0] imem_data,
    input  logic [`CPU_REG_AW-1:0] reg_sel,
    output logic [`CPU_DATA_W-1:0] reg_value
);

    logic [`CPU_PC_W-1:0]   pc;
    instr_t                 f_instr;
    instr_t                 d_instr;
    logic                   stall;
    logic                   fwd_rs;
    logic                   fwd_rt;
    logic [`CPU_DATA_W-1:0] rs_view;
    logic [1:0]             alu_flags;
    ctrl_t                  mem_ctrl;
    logic [`CPU_REG_AW-1:0] mem_dest;
    logic [`CPU_DATA_W-1:0] mem_alu_result;
    logic [`CPU_DATA_W-1:0] read_data;
    logic                   wb_en;
    logic [`CPU_REG_AW-1:0] wb_addr;
    logic [`CPU_DATA_W-1:0] wb_data;

    id_ex_if  id_ex  ();
    ex_mem_if ex_mem ();

    fetch_stage fetch_i (.SYS_clk, .SYS_reset, .load, .pc_val, .stall, .imem_we,
                         .imem_addr, .imem_data, .pc, .instr(f_instr));

    decode_stage decode_i (.SYS_clk, .SYS_reset, .load, .stall, .f_instr, .wb_en, .wb_addr,
                           .wb_data, .fwd_rs, .fwd_rt, .mem_alu_result, .reg_sel,
                           .d_instr, .rs_view, .reg_value, .id_ex);

    hazard_unit hazard_i (.d_instr, .id_ex, .ex_mem, .mem_ctrl, .mem_dest,
                          .stall, .fwd_rs, .fwd_rt);

    execute_stage execute_i (.SYS_clk, .SYS_reset, .id_ex, .ex_mem, .alu_flags);

    memory_stage memory_i (.SYS_clk, .SYS_reset, .ex_mem, .mem_ctrl, .mem_dest,
                           .mem_alu_result, .read_data, .wb_en, .wb_addr, .wb_data);

    // board display, wide sources cut to the low bits
    always_comb
    begin
        leds = '0;
        case (output_sel)
            `CPU_LED_FETCH: leds = `CPU_LED_W'(f_instr);
            `CPU_LED_RS:    leds = `CPU_LED_W'(rs_view);
            `CPU_LED_ALU:   leds = `CPU_LED_W'(ex_mem.alu_result);
            `CPU_LED_FLAGS: leds = `CPU_LED_W'(alu_flags);
            `CPU_LED_MEMRD: leds = `CPU_LED_W'(read_data);
            `CPU_LED_CTRL:  leds = `CPU_LED_W'(id_ex.ctrl);      // bubble while stalled
            `CPU_LED_ALUOP: leds = `CPU_LED_W'(id_ex.ctrl.alu_op);
            `CPU_LED_PC:    leds = `CPU_LED_W'(pc);
            default:        leds = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: tests/tb_mips_core.sv
// Pipeline core testbench
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module tb_mips_core import cpu_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int LOAD_WORDS  = 64;     // program plus trailing nops
    localparam int MAX_PROG    = 24;
    localparam int SWEEP       = 40;     // view sweep or register sweep
    localparam int RUN_LEN     = 2 + SWEEP + 3 * (LOAD_WORDS + 1 + 3 * MAX_PROG + 4 + SWEEP)
                                 + 2**`CPU_PC_W + 16;
    localparam int WATCHDOG_NS = 2 * RUN_LEN * CLK_PERIOD;

    logic                   SYS_clk;
    logic                   SYS_reset;
    logic                   load;
    logic [`CPU_PC_W-1:0]   pc_val;
    logic [2:0]             output_sel;
    logic [`CPU_LED_W-1:0]  leds;
    logic                   imem_we;
    logic [`CPU_PC_W-1:0]   imem_addr;
    logic [`CPU_DATA_W-1:0] imem_data;
    logic [`CPU_REG_AW-1:0] reg_sel;
    logic [`CPU_DATA_W-1:0] reg_value;

    logic [31:0] prog [$];
    logic [31:0] model_regs [32];        // sequential reference state
    logic [31:0] model_dmem [64];
    int          checks;
    int          errors;

    mips_core dut_i (.SYS_clk, .SYS_reset, .load, .pc_val, .output_sel, .leds, .imem_we,
                     .imem_addr, .imem_data, .reg_sel, .reg_value);

    initial
    begin
        SYS_clk = 1'b0;
        forever #(CLK_PERIOD / 2) SYS_clk = ~SYS_clk;
    end

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
        return {`CPU_OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] enc_sll(input logic [4:0] rd, input logic [4:0] rt,
                                            input logic [4:0] sh);
        return {`CPU_OP_RTYPE, 5'd0, rt, rd, sh, `CPU_FN_SLL};
    endfunction

    function automatic logic [31:0] enc_mul(input logic [4:0] rd, input logic [4:0] rs,
                                            input logic [4:0] rt);
        return {`CPU_OP_MUL, rs, rt, rd, 5'd0, `CPU_FN_MUL};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // any word whose value depends on every address bit
    function automatic logic [31:0] fill_word(input logic [7:0] a);
        return {a, ~a, a ^ 8'h5a, a + 8'd17};
    endfunction

    // executes one ISA instruction in program order
    task automatic step_model(input instr_t ins);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        a    = model_regs[ins.r_fmt.rs];
        b    = model_regs[ins.r_fmt.rt];
        addr = a + {{16{ins.i_fmt.imm[15]}}, ins.i_fmt.imm};
        dst  = ins.r_fmt.rd;
        wr   = 1'b1;
        res  = '0;
        case (ins.r_fmt.opcode)
            `CPU_OP_RTYPE:
                case (ins.r_fmt.funct)
                    `CPU_FN_ADD: res = a + b;
                    `CPU_FN_SUB: res = a - b;
                    `CPU_FN_AND: res = a & b;
                    `CPU_FN_OR:  res = a | b;
                    `CPU_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `CPU_FN_SLL: res = b << ins.r_fmt.shamt;
                    default:     wr = 1'b0;
                endcase
            `CPU_OP_MUL:
            begin
                wr  = (ins.r_fmt.funct == `CPU_FN_MUL);
                res = a * b;                     // low word
            end
            `CPU_OP_ADDI:
            begin
                dst = ins.i_fmt.rt;
                res = addr;
            end
            `CPU_OP_LW:
            begin
                dst = ins.i_fmt.rt;
                res = model_dmem[addr[7:2]];
            end
            `CPU_OP_SW:
            begin
                wr = 1'b0;
                model_dmem[addr[7:2]] = b;
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0)
            model_regs[dst] = res;
    endtask

    task automatic check_value(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", sig, got, exp);
        end
    endtask

    task automatic check_view(input logic [2:0] sel, input logic [26:0] exp);
        @(negedge SYS_clk);
        output_sel = sel;
        #1;
        check_value($sformatf("leds[output_sel=%0d]", sel), 32'(leds), 32'(exp));
    endtask

    task automatic check_regs();
        for (int r = 0; r < 32; r++)
        begin
            @(negedge SYS_clk);
            reg_sel = 5'(r);
            #1;
            check_value($sformatf("reg_value[r%0d]", r), reg_value, model_regs[r]);
        end
    endtask

    // loads and runs the program from pc 0 then compares with the model
    task automatic run_program();
        int cycles;
        cycles = 3 * prog.size() + 4;            // up to two stall cycles per instruction
        for (int a = 0; a < LOAD_WORDS; a++)
        begin
            @(negedge SYS_clk);
            imem_we   = 1'b1;
            imem_addr = 8'(a);
            imem_data = (a < prog.size()) ? prog[a] : 32'h0;
        end
        @(negedge SYS_clk);
        imem_we = 1'b0;
        load    = 1'b0;
        repeat (cycles) @(negedge SYS_clk);
        load = 1'b1;                             // park pc at 0 with bubbles behind
        foreach (prog[i])
            step_model(prog[i]);
        check_regs();
        prog.delete();
    endtask

    task automatic test_reset_state();
        ctrl_t       nop_ctrl;
        logic [26:0] exp_view [8];
        nop_ctrl = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, ALU_SLL};   // zero word is sll r0,r0,0
        foreach (exp_view[v])
            exp_view[v] = '0;
        exp_view[`CPU_LED_FLAGS] = 27'h2;        // zero flag for a zero result
        exp_view[`CPU_LED_CTRL]  = {18'h0, nop_ctrl};
        exp_view[`CPU_LED_ALUOP] = {23'h0, ALU_SLL};
        for (int v = 0; v < 8; v++)
            check_view(3'(v), exp_view[v]);
        check_regs();
    endtask

    task automatic test_alu_imm();
        for (int r = 1; r <= 8; r++)
            prog.push_back(enc_i(`CPU_OP_ADDI, 5'(r), 5'd0, 16'($urandom())));
        repeat (3)
            prog.push_back(32'h0);
        prog.push_back(enc_r(`CPU_FN_ADD, 5'd9, 5'd1, 5'd2));
        prog.push_back(enc_r(`CPU_FN_SUB, 5'd10, 5'd3, 5'd4));
        prog.push_back(enc_r(`CPU_FN_AND, 5'd11, 5'd5, 5'd6));
        prog.push_back(enc_r(`CPU_FN_OR, 5'd12, 5'd7, 5'd8));
        prog.push_back(enc_r(`CPU_FN_SLT, 5'd13, 5'd1, 5'd2));
        prog.push_back(enc_r(`CPU_FN_SLT, 5'd14, 5'd2, 5'd1));
        prog.push_back(enc_sll(5'd15, 5'd3, 5'($urandom())));
        prog.push_back(enc_mul(5'd16, 5'd4, 5'd5));
        prog.push_back(enc_i(`CPU_OP_ADDI, 5'd0, 5'd0, 16'($urandom())));  // r0 stays 0
        prog.push_back(enc_r(`CPU_FN_ADD, 5'd0, 5'd1, 5'd2));
        run_program();
    endtask

    task automatic test_dependencies();
        prog.push_back(enc_i(`CPU_OP_ADDI, 5'd20, 5'd0, 16'($urandom())));
        prog.push_back(enc_r(`CPU_FN_ADD, 5'd21, 5'd20, 5'd20));   // reads result directly
        prog.push_back(enc_r(`CPU_FN_SUB, 5'd22, 5'd21, 5'd20));
        prog.push_back(enc_i(`CPU_OP_ADDI, 5'd25, 5'd0, 16'($urandom())));
        prog.push_back(enc_r(`CPU_FN_OR, 5'd23, 5'd22, 5'd25));    // r22 two slots back
        prog.push_back(enc_mul(5'd24, 5'd23, 5'd21));
        prog.push_back(enc_i(`CPU_OP_ADDI, 5'd26, 5'd0, 16'($urandom())));
        prog.push_back(enc_r(`CPU_FN_ADD, 5'd27, 5'd24, 5'd26));
        prog.push_back(enc_r(`CPU_FN_SLT, 5'd28, 5'd27, 5'd24));
        prog.push_back(enc_sll(5'd29, 5'd28, 5'd3));
        run_program();
    endtask

    task automatic test_memory();
        logic [15:0] base;
        base = 16'(($urandom() % 56) * 4);
        prog.push_back(enc_i(`CPU_OP_ADDI, 5'd2, 5'd0, base));
        prog.push_back(enc_i(`CPU_OP_ADDI, 5'd3, 5'd0, 16'($urandom())));
        prog.push_back(enc_i(`CPU_OP_ADDI, 5'd4, 5'd0, 16'($urandom())));
        prog.push_back(enc_i(`CPU_OP_SW, 5'd3, 5'd2, 16'd0));
        prog.push_back(enc_i(`CPU_OP_SW, 5'd4, 5'd2, 16'd4));
        prog.push_back(enc_i(`CPU_OP_LW, 5'd5, 5'd2, 16'd0));
        prog.push_back(enc_r(`CPU_FN_ADD, 5'd6, 5'd5, 5'd4));      // load use
        prog.push_back(enc_i(`CPU_OP_LW, 5'd7, 5'd2, 16'd4));
        prog.push_back(enc_i(`CPU_OP_SW, 5'd7, 5'd2, 16'd8));
        prog.push_back(enc_mul(5'd8, 5'd3, 5'd4));
        prog.push_back(enc_i(`CPU_OP_SW, 5'd8, 5'd2, 16'd12));
        prog.push_back(enc_i(`CPU_OP_LW, 5'd9, 5'd2, 16'd12));
        prog.push_back(enc_i(`CPU_OP_LW, 5'd10, 5'd2, 16'd8));
        prog.push_back(enc_r(`CPU_FN_SUB, 5'd11, 5'd10, 5'd9));
        run_program();
    endtask

    task automatic test_pc_load();
        logic [7:0]  target;
        logic [31:0] word;
        for (int a = 0; a < 2**`CPU_PC_W; a++)
        begin
            @(negedge SYS_clk);
            imem_we   = 1'b1;
            imem_addr = 8'(a);
            imem_data = fill_word(8'(a));
        end
        repeat (4)
        begin
            @(negedge SYS_clk);
            imem_we = 1'b0;
            target  = 8'($urandom());
            pc_val  = target;                    // load stays high
            word    = fill_word(target);
            check_view(`CPU_LED_PC, {19'h0, target});
            check_view(`CPU_LED_FETCH, word[26:0]);
        end
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial
    begin
        void'($urandom(81));
        checks = 0;
        errors = 0;
        foreach (model_regs[i])
            model_regs[i] = '0;
        foreach (model_dmem[i])
            model_dmem[i] = '0;
        SYS_reset  = 1'b1;
        load       = 1'b1;                       // pipeline sees only bubbles
        pc_val     = '0;
        output_sel = '0;
        imem_we    = 1'b1;                       // word 0 cleared during reset
        imem_addr  = '0;
        imem_data  = '0;
        reg_sel    = '0;
        repeat (2) @(posedge SYS_clk);
        @(negedge SYS_clk);
        SYS_reset = 1'b0;
        imem_we   = 1'b0;

        test_reset_state();
        test_alu_imm();
        test_dependencies();
        test_memory();
        test_pc_load();

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+src
src/cpu_pkg.sv
src/cpu_ifs.sv
src/fetch_stage.sv
src/decode_stage.sv
src/hazard_unit.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
tests/tb_mips_core.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_mips_core -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"

if grep -qF '*** TEST PASSED ***' <<< "$out"
then
    exit 0
fi
exit 1
